// File: design/lsu_pkg.sv
// Load/store unit shared types
`default_nettype none

package lsu_pkg;

    //------------------------------------------------------------
    // Widths
    //------------------------------------------------------------

    localparam int unsigned lsu_xlen = 64;  // RV64 data and address width

    //------------------------------------------------------------
    // Execute-side command
    //------------------------------------------------------------

    typedef enum logic [3:0] {
        LSU_CMD_NONE,
        LSU_CMD_LB,
        LSU_CMD_LBU,
        LSU_CMD_LH,
        LSU_CMD_LHU,
        LSU_CMD_LW,
        LSU_CMD_LWU,
        LSU_CMD_LD,
        LSU_CMD_SB,
        LSU_CMD_SH,
        LSU_CMD_SW,
        LSU_CMD_SD
    } lsu_cmd_e;

    //------------------------------------------------------------
    // Data memory side
    //------------------------------------------------------------

    typedef enum logic {
        MEM_CMD_RD,
        MEM_CMD_WR
    } mem_cmd_e;

    // Encoded as log2 of the byte count
    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE  = 2'd0,
        MEM_WIDTH_HWORD = 2'd1,
        MEM_WIDTH_WORD  = 2'd2,
        MEM_WIDTH_DWORD = 2'd3
    } mem_width_e;

    typedef enum logic [1:0] {
        MEM_RESP_NOTRDY = 2'd0,  // No response this cycle
        MEM_RESP_RDY_OK = 2'd1,
        MEM_RESP_RDY_ER = 2'd2   // Bus error, becomes access fault
    } mem_resp_e;

    //------------------------------------------------------------
    // Exception codes, as in mcause
    //------------------------------------------------------------

    typedef enum logic [3:0] {
        EXC_CODE_NONE             = 4'd0,
        EXC_CODE_LD_ADDR_MISALIGN = 4'd4,
        EXC_CODE_LD_ACCESS_FAULT  = 4'd5,
        EXC_CODE_ST_ADDR_MISALIGN = 4'd6,
        EXC_CODE_ST_ACCESS_FAULT  = 4'd7
    } exc_code_e;

    // Decoded operation, 5 bits
    typedef struct packed {
        logic       is_load;
        logic       is_store;
        mem_width_e width;
        logic       sign_ext;  // Only meaningful for loads
    } lsu_op_s;

endpackage : lsu_pkg

`default_nettype wire

// File: design/lsu_cmd_decode.sv
// LSU command decoder
`timescale 1ns/1ps
`default_nettype none

module lsu_cmd_decode
    import lsu_pkg::*;
(
    input  lsu_cmd_e cmd_i,  // Command from execute
    output lsu_op_s  op_o    // Direction, width, signedness
);

    //------------------------------------------------------------
    // Command to operation map
    //------------------------------------------------------------

    always_comb begin
        op_o = '0;  // NONE and unused codes: no access
        case (cmd_i)
            LSU_CMD_LB: begin
                op_o.is_load  = 1'b1;
                op_o.width    = MEM_WIDTH_BYTE;
                op_o.sign_ext = 1'b1;
            end
            LSU_CMD_LBU: begin
                op_o.is_load  = 1'b1;
                op_o.width    = MEM_WIDTH_BYTE;
            end
            LSU_CMD_LH: begin
                op_o.is_load  = 1'b1;
                op_o.width    = MEM_WIDTH_HWORD;
                op_o.sign_ext = 1'b1;
            end
            LSU_CMD_LHU: begin
                op_o.is_load  = 1'b1;
                op_o.width    = MEM_WIDTH_HWORD;
            end
            LSU_CMD_LW: begin
                op_o.is_load  = 1'b1;
                op_o.width    = MEM_WIDTH_WORD;
                op_o.sign_ext = 1'b1;
            end
            LSU_CMD_LWU: begin
                op_o.is_load  = 1'b1;
                op_o.width    = MEM_WIDTH_WORD;
            end
            LSU_CMD_LD: begin
                op_o.is_load  = 1'b1;             // Full width, extension moot
                op_o.width    = MEM_WIDTH_DWORD;
            end
            LSU_CMD_SB: begin
                op_o.is_store = 1'b1;
                op_o.width    = MEM_WIDTH_BYTE;
            end
            LSU_CMD_SH: begin
                op_o.is_store = 1'b1;
                op_o.width    = MEM_WIDTH_HWORD;
            end
            LSU_CMD_SW: begin
                op_o.is_store = 1'b1;
                op_o.width    = MEM_WIDTH_WORD;
            end
            LSU_CMD_SD: begin
                op_o.is_store = 1'b1;
                op_o.width    = MEM_WIDTH_DWORD;
            end
            default: ;
        endcase

        // Direction must be one-hot or idle
        assert (!(op_o.is_load && op_o.is_store))
            else $error("lsu_cmd_decode: load and store both set for cmd %0d", cmd_i);
    end

endmodule : lsu_cmd_decode

`default_nettype wire

// File: design/lsu_exc_gen.sv
// LSU exception generator
`timescale 1ns/1ps
`default_nettype none

module lsu_exc_gen
    import lsu_pkg::*;
(
    input  logic      req_i,       // Execute request strobe
    input  lsu_op_s   req_op_i,    // Decoded current command
    input  logic[2:0] addr_lo_i,   // Low address bits
    input  lsu_op_s   op_q_i,      // Operation in flight
    input  mem_resp_e resp_i,      // Memory response code
    output logic      misalign_o,  // Blocks the memory request
    output logic      exc_o,
    output exc_code_e exc_code_o
);

    logic addr_bad;  // Low bits nonzero for the width
    logic resp_er;

    //------------------------------------------------------------
    // Misalign check, request cycle
    //------------------------------------------------------------

    always_comb begin
        case (req_op_i.width)
            MEM_WIDTH_HWORD: addr_bad = addr_lo_i[0];
            MEM_WIDTH_WORD:  addr_bad = |addr_lo_i[1:0];
            MEM_WIDTH_DWORD: addr_bad = |addr_lo_i[2:0];
            default:         addr_bad = 1'b0;  // Bytes never fault
        endcase
    end

    assign misalign_o = req_i & addr_bad & (req_op_i.is_load | req_op_i.is_store);

    assign resp_er = (resp_i == MEM_RESP_RDY_ER);  // Access fault source

    //------------------------------------------------------------
    // Code select, bus error first
    //------------------------------------------------------------

    always_comb begin
        if (resp_er) begin
            exc_code_o = op_q_i.is_store ? EXC_CODE_ST_ACCESS_FAULT
                                         : EXC_CODE_LD_ACCESS_FAULT;
        end else if (misalign_o) begin
            exc_code_o = req_op_i.is_store ? EXC_CODE_ST_ADDR_MISALIGN
                                           : EXC_CODE_LD_ADDR_MISALIGN;
        end else begin
            exc_code_o = EXC_CODE_NONE;
        end
    end

    assign exc_o = resp_er | misalign_o;

    // No exception without a request or a response behind it
    always_comb begin
        assert (!exc_o || req_i || (resp_i != MEM_RESP_NOTRDY))
            else $error("lsu_exc_gen: exception with no request and no response");
    end

endmodule : lsu_exc_gen

`default_nettype wire

// File: design/lsu_dmem_fsm.sv
// LSU data memory controller
`timescale 1ns/1ps
`default_nettype none

module lsu_dmem_fsm
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req_i,       // Execute request strobe
    input  logic      misalign_i,  // Request would fault
    input  lsu_op_s   req_op_i,    // Decoded current command
    input  logic      ack_i,       // Memory takes the request
    input  mem_resp_e resp_i,
    output logic      dmem_req_o,
    output logic      rdy_o,       // Response cycle
    output lsu_op_s   op_q_o       // Operation in flight
);

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } fsm_state_e;

    fsm_state_e state_q;
    fsm_state_e state_d;
    logic       accept;     // Request and ack in idle
    logic       resp_rcvd;  // OK or error

    //------------------------------------------------------------
    // Handshake
    //------------------------------------------------------------

    assign dmem_req_o = (state_q == ST_IDLE) & req_i & ~misalign_i;
    assign accept     = dmem_req_o & ack_i;
    assign resp_rcvd  = (resp_i == MEM_RESP_RDY_OK) | (resp_i == MEM_RESP_RDY_ER);
    assign rdy_o      = resp_rcvd;

    //------------------------------------------------------------
    // State and operation registers
    //------------------------------------------------------------

    always_comb begin
        case (state_q)
            ST_IDLE: state_d = accept    ? ST_BUSY : ST_IDLE;
            ST_BUSY: state_d = resp_rcvd ? ST_IDLE : ST_BUSY;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            op_q_o  <= '0;  // Neither load nor store
        end else begin
            state_q <= state_d;
            if (accept) op_q_o <= req_op_i;  // Held until next acceptance
        end
    end

    //------------------------------------------------------------
    // Protocol checks
    //------------------------------------------------------------

    a_no_resp_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state_q == ST_IDLE) |-> !resp_rcvd)
        else $error("lsu_dmem_fsm: memory response while idle");

    a_single_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> !dmem_req_o)
        else $error("lsu_dmem_fsm: memory request issued while busy");

    a_no_req_misalign: assert property (@(posedge clk) disable iff (!rst_n)
        !(dmem_req_o && misalign_i))
        else $error("lsu_dmem_fsm: memory request on misaligned access");

endmodule : lsu_dmem_fsm

`default_nettype wire

// File: design/lsu_load_align.sv
// LSU load data extension
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align
    import lsu_pkg::*;
(
    input  lsu_op_s              op_q_i,   // Operation in flight
    input  logic[lsu_xlen-1:0]   rdata_i,  // Raw memory read data
    output logic[lsu_xlen-1:0]   ldata_o   // Extended load result
);

    logic sgn;  // Fill bit for the upper part

    //------------------------------------------------------------
    // Width select and extension
    //------------------------------------------------------------

    always_comb begin
        sgn = 1'b0;
        case (op_q_i.width)
            MEM_WIDTH_BYTE: begin
                sgn     = op_q_i.sign_ext & rdata_i[7];
                ldata_o = {{56{sgn}}, rdata_i[7:0]};
            end
            MEM_WIDTH_HWORD: begin
                sgn     = op_q_i.sign_ext & rdata_i[15];
                ldata_o = {{48{sgn}}, rdata_i[15:0]};
            end
            MEM_WIDTH_WORD: begin
                sgn     = op_q_i.sign_ext & rdata_i[31];  // LW vs LWU
                ldata_o = {{32{sgn}}, rdata_i[31:0]};
            end
            default: begin
                ldata_o = rdata_i;  // Doubleword as is
            end
        endcase
    end

endmodule : lsu_load_align

`default_nettype wire

// File: design/lsu_top.sv
// Load/store unit top level
`timescale 1ns/1ps
`default_nettype none

module lsu_top
    import lsu_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    // Execute side
    input  logic                req_i,
    input  lsu_cmd_e            cmd_i,
    input  logic[lsu_xlen-1:0]  addr_i,
    input  logic[lsu_xlen-1:0]  sdata_i,       // Store data
    output logic                rdy_o,
    output logic[lsu_xlen-1:0]  ldata_o,
    output logic                exc_o,
    output exc_code_e           exc_code_o,
    // Data memory side
    output logic                dmem_req_o,
    output mem_cmd_e            dmem_cmd_o,
    output mem_width_e          dmem_width_o,
    output logic[lsu_xlen-1:0]  dmem_addr_o,
    output logic[lsu_xlen-1:0]  dmem_wdata_o,
    input  logic                dmem_ack_i,
    input  logic[lsu_xlen-1:0]  dmem_rdata_i,
    input  mem_resp_e           dmem_resp_i
);

    lsu_op_s req_op;    // Decoded current command
    lsu_op_s op_q;      // Registered in controller
    logic    misalign;

    lsu_cmd_decode lsu_cmd_decode_inst (
        .cmd_i (cmd_i),
        .op_o  (req_op)
    );

    lsu_exc_gen lsu_exc_gen_inst (
        .req_i      (req_i),
        .req_op_i   (req_op),
        .addr_lo_i  (addr_i[2:0]),
        .op_q_i     (op_q),
        .resp_i     (dmem_resp_i),
        .misalign_o (misalign),
        .exc_o      (exc_o),
        .exc_code_o (exc_code_o)
    );

    lsu_dmem_fsm lsu_dmem_fsm_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_i      (req_i),
        .misalign_i (misalign),
        .req_op_i   (req_op),
        .ack_i      (dmem_ack_i),
        .resp_i     (dmem_resp_i),
        .dmem_req_o (dmem_req_o),
        .rdy_o      (rdy_o),
        .op_q_o     (op_q)
    );

    lsu_load_align lsu_load_align_inst (
        .op_q_i  (op_q),
        .rdata_i (dmem_rdata_i),
        .ldata_o (ldata_o)
    );

    // Memory command fields straight from the decoder
    assign dmem_cmd_o   = req_op.is_store ? MEM_CMD_WR : MEM_CMD_RD;
    assign dmem_width_o = req_op.width;
    assign dmem_addr_o  = addr_i;
    assign dmem_wdata_o = sdata_i;  // No lane shifting, memory merges by width

endmodule : lsu_top

`default_nettype wire

// File: tests/lsu_tb.sv
// Load/store unit testbench
`timescale 1ns/1ps
`default_nettype none

module lsu_tb
    import lsu_pkg::*;
;
    localparam int n_tx_max = 120;                      // Upper bound on transactions
    localparam logic [63:0] err_lo = 64'hF000_0000;     // Error range answers RDY_ER
    localparam logic [63:0] err_hi = 64'hF000_0FFF;

    logic clk;
    logic rst_n;
    logic req_i;
    lsu_cmd_e cmd_i;
    logic [lsu_xlen-1:0] addr_i, sdata_i, ldata_o, dmem_addr_o, dmem_wdata_o, dmem_rdata_i;
    logic rdy_o, exc_o, dmem_req_o, dmem_ack_i;
    exc_code_e exc_code_o;
    mem_cmd_e dmem_cmd_o;
    mem_width_e dmem_width_o;
    mem_resp_e dmem_resp_i;

    logic [7:0] mem [logic [63:0]];  // Sparse byte memory
    logic [31:0] lfsr;
    logic outstanding;               // Accepted, response not yet seen
    int ack_wait, resp_wait, n_acc, n_rdy, n_tx, errors, slow;
    logic [63:0] acc_addr;
    logic exp_mis, exp_fault, exp_load;
    exc_code_e exp_code;
    logic [63:0] exp_ldata;
    logic [63:0] exp_addr;           // Memory-side address of the current access
    logic [63:0] exp_wdata;          // Store data of the current access
    int exp_nbytes;                  // Access size in bytes

    lsu_top lsu_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // Galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic [63:0] read_bytes(input logic [63:0] a);
        logic [63:0] r;
        for (int i = 0; i < 8; i++) begin
            r[8*i +: 8] = mem.exists(a + 64'(i)) ? mem[a + 64'(i)] : 8'h00;
        end
        return r;
    endfunction

    function automatic int nbytes(input lsu_cmd_e c);
        case (c)
            LSU_CMD_LH, LSU_CMD_LHU, LSU_CMD_SH: return 2;
            LSU_CMD_LW, LSU_CMD_LWU, LSU_CMD_SW: return 4;
            LSU_CMD_LD, LSU_CMD_SD:              return 8;
            default:                             return 1;
        endcase
    endfunction

    // Expected load result, extension per ISA
    function automatic logic [63:0] load_expect(input lsu_cmd_e c, input logic [63:0] a);
        logic [63:0] raw;
        raw = read_bytes(a);
        case (c)
            LSU_CMD_LB:  return {{56{raw[7]}}, raw[7:0]};
            LSU_CMD_LBU: return {56'h0, raw[7:0]};
            LSU_CMD_LH:  return {{48{raw[15]}}, raw[15:0]};
            LSU_CMD_LHU: return {48'h0, raw[15:0]};
            LSU_CMD_LW:  return {{32{raw[31]}}, raw[31:0]};
            LSU_CMD_LWU: return {32'h0, raw[31:0]};
            default:     return raw;
        endcase
    endfunction

    //------------------------------------------------------------
    // Memory model with random ack and response delays
    //------------------------------------------------------------

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dmem_ack_i   <= 1'b0;
            dmem_resp_i  <= MEM_RESP_NOTRDY;
            dmem_rdata_i <= '0;
            outstanding  <= 1'b0;
            ack_wait     <= 0;
            resp_wait    <= 0;
        end else begin
            dmem_ack_i  <= 1'b0;
            dmem_resp_i <= MEM_RESP_NOTRDY;
            if (dmem_resp_i != MEM_RESP_NOTRDY) outstanding <= 1'b0;  // Response cycle over
            if (dmem_req_o && dmem_ack_i) begin
                outstanding <= 1'b1;
                n_acc++;
                acc_addr = dmem_addr_o;
                resp_wait <= int'(rand_bits(2));
                ack_wait  <= int'(rand_bits(2)) + slow;
                if (dmem_cmd_o == MEM_CMD_WR && !(acc_addr >= err_lo && acc_addr <= err_hi)) begin
                    for (int i = 0; i < (1 << dmem_width_o); i++) begin
                        mem[acc_addr + 64'(i)] = dmem_wdata_o[8*i +: 8];  // Merge by width
                    end
                end
            end else if (dmem_req_o && !dmem_ack_i) begin
                if (ack_wait == 0) dmem_ack_i <= 1'b1;
                else ack_wait <= ack_wait - 1;
            end
            if (outstanding && dmem_resp_i == MEM_RESP_NOTRDY) begin
                if (resp_wait == 0) begin
                    if (acc_addr >= err_lo && acc_addr <= err_hi) begin
                        dmem_resp_i  <= MEM_RESP_RDY_ER;
                        dmem_rdata_i <= '0;
                    end else begin
                        dmem_resp_i  <= MEM_RESP_RDY_OK;
                        dmem_rdata_i <= read_bytes(acc_addr);
                    end
                end else begin
                    resp_wait <= resp_wait - 1;
                end
            end
        end
    end

    // Ready pulses from the DUT
    always @(posedge clk) begin
        if (rst_n && rdy_o) n_rdy++;
    end

    //------------------------------------------------------------
    // Checking assertions
    //------------------------------------------------------------

    a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (!req_i && !outstanding) |-> (!dmem_req_o && !rdy_o && !exc_o))
        else begin
            errors++;
            $display("Activity on an idle unit at %0t", $time);
        end

    a_misalign: assert property (@(posedge clk) disable iff (!rst_n)
        (req_i && exp_mis) |-> (exc_o && !dmem_req_o && exc_code_o == exp_code))
        else begin
            errors++;
            $display("error at %0t: exc_code_o expected %0d got %0d (exc_o %b, dmem_req_o %b)",
                     $time, exp_code, $sampled(exc_code_o), $sampled(exc_o),
                     $sampled(dmem_req_o));
        end

    a_req_pending: assert property (@(posedge clk) disable iff (!rst_n)
        (req_i && !exp_mis && !outstanding) |-> (dmem_req_o && !rdy_o))
        else begin
            errors++;
            $display("Memory request missing while waiting at %0t", $time);
        end

    a_busy: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding |-> !dmem_req_o)
        else begin
            errors++;
            $display("Second request while one is outstanding at %0t", $time);
        end

    // Address, direction and size seen by memory
    a_mem_fields: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req_o |-> (dmem_addr_o == exp_addr
                        && dmem_cmd_o == (exp_load ? MEM_CMD_RD : MEM_CMD_WR)
                        && (1 << dmem_width_o) == exp_nbytes))
        else begin
            errors++;
            $display("error at %0t: dmem_addr_o/cmd/bytes expected %h/%0d/%0d got %h/%0d/%0d",
                     $time, exp_addr, !exp_load, exp_nbytes, $sampled(dmem_addr_o),
                     $sampled(dmem_cmd_o), 1 << $sampled(dmem_width_o));
        end

    a_wdata: assert property (@(posedge clk) disable iff (!rst_n)
        (dmem_req_o && !exp_load) |-> (dmem_wdata_o == exp_wdata))
        else begin
            errors++;
            $display("error at %0t: dmem_wdata_o expected %h got %h",
                     $time, exp_wdata, $sampled(dmem_wdata_o));
        end

    a_fault: assert property (@(posedge clk) disable iff (!rst_n)
        rdy_o |-> (exc_o == exp_fault))
        else begin
            errors++;
            $display("error at %0t: exc_o expected %b got %b", $time, exp_fault, $sampled(exc_o));
        end

    a_code: assert property (@(posedge clk) disable iff (!rst_n)
        (rdy_o && exp_fault) |-> (exc_code_o == exp_code))
        else begin
            errors++;
            $display("error at %0t: exc_code_o expected %0d got %0d",
                     $time, exp_code, $sampled(exc_code_o));
        end

    a_ldata: assert property (@(posedge clk) disable iff (!rst_n)
        (rdy_o && exp_load && !exp_fault) |-> (ldata_o == exp_ldata))
        else begin
            errors++;
            $display("error at %0t: ldata_o expected %h got %h",
                     $time, exp_ldata, $sampled(ldata_o));
        end

    //------------------------------------------------------------
    // Stimulus
    //------------------------------------------------------------

    task automatic access(input lsu_cmd_e c, input logic [63:0] a, input logic [63:0] d);
        logic mis;
        logic flt;
        logic ld;
        @(posedge clk);
        ld  = (c inside {LSU_CMD_LB, LSU_CMD_LBU, LSU_CMD_LH, LSU_CMD_LHU,
                         LSU_CMD_LW, LSU_CMD_LWU, LSU_CMD_LD});
        mis = (a & 64'(nbytes(c) - 1)) != 64'h0;
        flt = !mis && a >= err_lo && a <= err_hi;
        exp_mis    <= mis;
        exp_fault  <= flt;
        exp_load   <= ld;
        exp_ldata  <= load_expect(c, a);
        exp_addr   <= a;
        exp_wdata  <= d;
        exp_nbytes <= nbytes(c);
        if (mis) exp_code <= ld ? EXC_CODE_LD_ADDR_MISALIGN : EXC_CODE_ST_ADDR_MISALIGN;
        else if (flt) exp_code <= ld ? EXC_CODE_LD_ACCESS_FAULT : EXC_CODE_ST_ACCESS_FAULT;
        else exp_code <= EXC_CODE_NONE;
        req_i   <= 1'b1;
        cmd_i   <= c;
        addr_i  <= a;
        sdata_i <= d;
        do @(posedge clk); while (!(rdy_o || exc_o));  // Held until ready or exception
        req_i <= 1'b0;
        cmd_i <= LSU_CMD_NONE;
        n_tx++;
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("test %-12s done, %0d errors", name, errors - err_before);
    endtask

    initial begin
        automatic int e0;
        automatic logic [63:0] base;
        lfsr = 32'h47f4bd36;
        rst_n = 1'b0;
        req_i = 1'b0;
        cmd_i = LSU_CMD_NONE;
        addr_i = '0;
        sdata_i = '0;
        dmem_ack_i = 1'b0;
        dmem_rdata_i = '0;
        dmem_resp_i = MEM_RESP_NOTRDY;
        outstanding = 1'b0;
        exp_mis = 1'b0;
        exp_fault = 1'b0;
        exp_load = 1'b0;
        exp_code = EXC_CODE_NONE;
        exp_ldata = '0;
        exp_addr = '0;
        exp_wdata = '0;
        exp_nbytes = 1;
        n_acc = 0;
        n_rdy = 0;
        n_tx = 0;
        errors = 0;
        slow = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        e0 = errors;
        repeat (4) @(posedge clk);  // Idle unit stays quiet
        report_test("reset", e0);

        e0 = errors;
        for (int k = 0; k < 8; k++) begin
            base = 64'h1000 + 64'(rand_bits(12)) * 64'd8;
            access(LSU_CMD_SD, base, {rand_bits(32), rand_bits(32)});
            access(LSU_CMD_SW, base + 64'd4, {rand_bits(32), rand_bits(32)});
            access(LSU_CMD_SH, base + 64'd2, {rand_bits(32), rand_bits(32)});
            access(LSU_CMD_SB, base + 64'd1, {rand_bits(32), rand_bits(32)});
            access(LSU_CMD_LB, base + 64'd1, '0);
            access(LSU_CMD_LBU, base + 64'd7, '0);
            access(LSU_CMD_LH, base + 64'd2, '0);
            access(LSU_CMD_LHU, base + 64'd6, '0);
            access(LSU_CMD_LW, base + 64'd4, '0);
            access(LSU_CMD_LWU, base, '0);
            access(LSU_CMD_LD, base, '0);
        end
        report_test("round_trip", e0);

        e0 = errors;
        access(LSU_CMD_LH, 64'h2001, '0);
        access(LSU_CMD_SH, 64'h2003, 64'h55);
        access(LSU_CMD_LW, 64'h2002, '0);
        access(LSU_CMD_SW, 64'h2006, 64'h66);
        access(LSU_CMD_LD, 64'h2004, '0);
        access(LSU_CMD_SD, 64'h2007, 64'h77);
        access(LSU_CMD_LB, 64'h2003, '0);  // Bytes never fault
        report_test("misalign", e0);

        e0 = errors;
        access(LSU_CMD_LD, err_lo + 64'h10, '0);
        access(LSU_CMD_SD, err_lo + 64'h18, 64'h1234);
        access(LSU_CMD_LBU, err_lo + 64'h3, '0);
        access(LSU_CMD_SW, err_lo + 64'h20, 64'h5678);
        report_test("fault", e0);

        e0 = errors;
        slow = 4;  // Longer ack stalls
        for (int k = 0; k < 16; k++) begin
            base = 64'h3000 + 64'(rand_bits(8)) * 64'd8;
            access(k[0] ? LSU_CMD_LD : LSU_CMD_SD, base, {rand_bits(32), rand_bits(32)});
        end
        repeat (2) @(posedge clk);
        assert (n_acc == n_rdy) else begin
            errors++;
            $display("error at %0t: rdy_o count expected %0d got %0d", $time, n_acc, n_rdy);
        end
        report_test("backpressure", e0);

        $display("%0d transactions, %0d errors", n_tx, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog, 200 cycles per transaction
    initial begin
        repeat (200 * n_tx_max) @(posedge clk);
        $display("Watchdog expired before the tests completed");
        $display("Some tests failed");
        $finish;
    end

endmodule : lsu_tb

`default_nettype wire

// File: lsu_top.f
design/lsu_pkg.sv
design/lsu_cmd_decode.sv
design/lsu_exc_gen.sv
design/lsu_dmem_fsm.sv
design/lsu_load_align.sv
design/lsu_top.sv
tests/lsu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f lsu_top.f \
    --top-module lsu_tb \
    -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/Vlsu_tb)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
